/* arith_cfg.svh */
// Word format of the machine is fixed here; the step count must equal the magnitude width over the digit width.
`ifndef ARITH_CFG_SVH
`define ARITH_CFG_SVH

// Magnitude bits of one word, the sign bit comes on top.
`define ARITH_MAG_W 30

// Bits retired per iteration (radix 8).
`define ARITH_DIGIT_W 3

// Iterations per multiply or divide.
`define ARITH_STEPS 10

`endif

/* arith_num_pkg.sv */
// Sign-magnitude number types only; a double word carries one sign bit over a 60-bit magnitude.
`default_nettype none

`include "arith_cfg.svh"

package arith_num_pkg;

	typedef logic [`ARITH_MAG_W-1:0] mag_t;           // Word magnitude.
	typedef logic [`ARITH_MAG_W:0] word_t;            // Sign in the top bit.
	typedef logic [2*`ARITH_MAG_W-1:0] dmag_t;        // Double-word magnitude.
	typedef logic [2*`ARITH_MAG_W:0] dword_t;         // Sign in the top bit.

	// Quotient or multiplier digit.
	typedef logic [`ARITH_DIGIT_W-1:0] digit_t;

	typedef logic [3:0] step_t;                       // Counts up to ARITH_STEPS-1.

endpackage

`default_nettype wire

/* arith_ctl_pkg.sv */
// Control encodings; command codes other than CMD_MUL and CMD_DIV are legal inputs but answered as illegal.
`default_nettype none

package arith_ctl_pkg;

	typedef enum logic [2:0] {
		CMD_MUL = 3'd3,
		CMD_DIV = 3'd4
	} cmd_t;

	typedef enum logic [1:0] {
		ST_OK       = 2'd0,
		ST_OVERFLOW = 2'd1,
		ST_ILLEGAL  = 2'd2
	} status_t;

	// Shared by both iterative units.
	typedef enum logic [1:0] {U_IDLE, U_LOAD, U_STEP, U_DONE} unit_state_t;

	typedef enum logic [1:0] {
		C_IDLE,
		C_BUSY,
		C_HOLD                                        // Result waits for res_ready.
	} core_state_t;

endpackage

`default_nettype wire

/* arith_unit_if.sv */
// Operands are valid only with start, results only with done; start is never repeated before done.
`default_nettype none

interface arith_unit_if import arith_num_pkg::*; ();

	logic start;                                      // One cycle.
	dword_t op_a;
	word_t op_b;
	logic done;                                       // One cycle.
	word_t res_hi;
	word_t res_lo;
	logic overflow;

	modport ctrl (
		output start,
		output op_a,
		output op_b,
		input done,
		input res_hi,
		input res_lo,
		input overflow
	);

	modport unit (
		input start,
		input op_a,
		input op_b,
		output done,
		output res_hi,
		output res_lo,
		output overflow
	);

endinterface

`default_nettype wire

/* mul_radix8.sv */
// Only the low word of op_a is the multiplier; done comes 12 cycles after start and overflow is always low.
`default_nettype none

`include "arith_cfg.svh"

module mul_radix8 import arith_num_pkg::*, arith_ctl_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	arith_unit_if.unit bus
);

	unit_state_t state;
	step_t step;

	mag_t mcand;
	mag_t mplier;
	dmag_t prod;
	logic sign;
	digit_t digit;

	// Digits are consumed from the top of the multiplier.
	assign digit = mplier[`ARITH_MAG_W-1 -: `ARITH_DIGIT_W];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= U_IDLE;
			step <= '0;
		end else begin
			case (state)
				U_IDLE: begin
					if (bus.start) begin
						state <= U_LOAD;
					end
				end
				U_LOAD: begin
					step <= '0;
					state <= U_STEP;
				end
				U_STEP: begin
					step <= step + 1'b1;
					if (step == step_t'(`ARITH_STEPS - 1)) begin
						state <= U_DONE;
					end
				end
				default: state <= U_IDLE;         // U_DONE lasts one cycle.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == U_IDLE && bus.start) begin
			mcand <= bus.op_b[`ARITH_MAG_W-1:0];
			mplier <= bus.op_a[`ARITH_MAG_W-1:0];
			sign <= bus.op_a[2*`ARITH_MAG_W] ^ bus.op_b[`ARITH_MAG_W];
		end else if (state == U_LOAD) begin
			prod <= '0;
		end else if (state == U_STEP) begin
			prod <= (prod << `ARITH_DIGIT_W) + (dmag_t'(mcand) * dmag_t'(digit));
			mplier <= mplier << `ARITH_DIGIT_W;
		end
	end

	assign bus.done = (state == U_DONE);
	assign bus.overflow = 1'b0;
	assign bus.res_hi = {sign & (|prod), prod[2*`ARITH_MAG_W-1:`ARITH_MAG_W]};   // No negative zero.
	assign bus.res_lo = {1'b0, prod[`ARITH_MAG_W-1:0]};

endmodule

`default_nettype wire

/* div_radix8.sv */
// Restoring divide of a double word by a word; on overflow both results read zero and done still comes after 12 cycles.
`default_nettype none

`include "arith_cfg.svh"

module div_radix8 import arith_num_pkg::*, arith_ctl_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	arith_unit_if.unit bus
);

	localparam int WIDE_W = 2 * `ARITH_MAG_W + `ARITH_DIGIT_W;

	unit_state_t state;
	step_t step;

	dmag_t rem;                                       // Partial remainder.
	dmag_t dsr;                                       // Divisor aligned to the current digit.
	mag_t quo;
	logic ovf;
	logic qsign;
	logic rsign;

	digit_t digit;
	dmag_t rem_next;

	// Largest multiple of the aligned divisor that still fits.
	always_comb begin
		logic [WIDE_W-1:0] trial;
		digit = '0;
		rem_next = rem;
		for (int k = 1; k < (1 << `ARITH_DIGIT_W); k++) begin
			trial = WIDE_W'(dsr) * WIDE_W'(k);
			if (trial <= WIDE_W'(rem)) begin
				digit = digit_t'(k);
				rem_next = dmag_t'(WIDE_W'(rem) - trial);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= U_IDLE;
			step <= '0;
		end else begin
			case (state)
				U_IDLE: begin
					if (bus.start) begin
						state <= U_LOAD;
					end
				end
				U_LOAD: begin
					step <= '0;
					state <= U_STEP;
				end
				U_STEP: begin
					step <= step + 1'b1;
					if (step == step_t'(`ARITH_STEPS - 1)) begin
						state <= U_DONE;
					end
				end
				default: state <= U_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == U_IDLE && bus.start) begin
			// High half must be below the divisor or the quotient needs more than 30 bits.
			ovf <= (bus.op_b[`ARITH_MAG_W-1:0] == '0) ||
				(bus.op_a[2*`ARITH_MAG_W-1:`ARITH_MAG_W] >= bus.op_b[`ARITH_MAG_W-1:0]);
			qsign <= bus.op_a[2*`ARITH_MAG_W] ^ bus.op_b[`ARITH_MAG_W];
			rsign <= bus.op_a[2*`ARITH_MAG_W];
			rem <= bus.op_a[2*`ARITH_MAG_W-1:0];
			dsr <= dmag_t'(bus.op_b[`ARITH_MAG_W-1:0]) << (`ARITH_MAG_W - `ARITH_DIGIT_W);
		end else if (state == U_LOAD) begin
			quo <= '0;
		end else if (state == U_STEP) begin
			rem <= rem_next;
			quo <= {quo[`ARITH_MAG_W-`ARITH_DIGIT_W-1:0], digit};
			dsr <= dsr >> `ARITH_DIGIT_W;
		end
	end

	assign bus.done = (state == U_DONE);
	assign bus.overflow = ovf;
	assign bus.res_hi = ovf ? '0 : {qsign & (|quo), quo};
	assign bus.res_lo = ovf ? '0 :
		{rsign & (|rem[`ARITH_MAG_W-1:0]), rem[`ARITH_MAG_W-1:0]};   // Remainder keeps dividend sign.

endmodule

`default_nettype wire

/* arith_core.sv */
// One command in flight; results hold until res_ready, MUL and DIV answer after 14 cycles, illegal codes after one.
`default_nettype none

module arith_core import arith_num_pkg::*, arith_ctl_pkg::*; (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic cmd_valid,
	output logic cmd_ready,
	input wire cmd_t cmd,
	input wire dword_t op_a,
	input wire word_t op_b,
	output logic res_valid,
	input wire logic res_ready,
	output word_t res_hi,
	output word_t res_lo,
	output status_t res_status
);

	arith_unit_if mul_bus ();
	arith_unit_if div_bus ();

	core_state_t state;
	dword_t op_a_r;
	word_t op_b_r;

	logic accept;
	logic legal;
	logic unit_done;
	word_t done_hi;
	word_t done_lo;
	logic done_ovf;

	assign cmd_ready = (state == C_IDLE);
	assign res_valid = (state == C_HOLD);
	assign accept = cmd_valid && cmd_ready;
	assign legal = (cmd == CMD_MUL) || (cmd == CMD_DIV);

	// Both units see the same registered operands.
	assign mul_bus.op_a = op_a_r;
	assign mul_bus.op_b = op_b_r;
	assign div_bus.op_a = op_a_r;
	assign div_bus.op_b = op_b_r;

	assign unit_done = mul_bus.done || div_bus.done;
	assign done_hi = mul_bus.done ? mul_bus.res_hi : div_bus.res_hi;
	assign done_lo = mul_bus.done ? mul_bus.res_lo : div_bus.res_lo;
	assign done_ovf = mul_bus.done ? mul_bus.overflow : div_bus.overflow;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= C_IDLE;
			mul_bus.start <= 1'b0;
			div_bus.start <= 1'b0;
		end else begin
			mul_bus.start <= 1'b0;
			div_bus.start <= 1'b0;
			case (state)
				C_IDLE: begin
					if (accept) begin
						mul_bus.start <= (cmd == CMD_MUL);
						div_bus.start <= (cmd == CMD_DIV);
						state <= legal ? C_BUSY : C_HOLD;
					end
				end
				C_BUSY: begin
					if (unit_done) begin
						state <= C_HOLD;
					end
				end
				C_HOLD: begin
					if (res_ready) begin
						state <= C_IDLE;
					end
				end
				default: state <= C_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			op_a_r <= op_a;
			op_b_r <= op_b;
			if (!legal) begin
				res_hi <= '0;
				res_lo <= '0;
				res_status <= ST_ILLEGAL;
			end
		end else if (state == C_BUSY && unit_done) begin
			res_hi <= done_hi;
			res_lo <= done_lo;
			res_status <= done_ovf ? ST_OVERFLOW : ST_OK;
		end
	end

	mul_radix8 i_mul (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (mul_bus.unit)
	);

	div_radix8 i_div (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (div_bus.unit)
	);

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// Free-running 8 ns clock; rst_n stays low for five rising edges and is released on a falling edge.
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;                            // Half of the 8 ns period.
		end
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* tb_arith.sv */
// Directed tests of arith_core with fixed-seed LFSR operands; the run stops at the first mismatch.
`default_nettype none

`include "arith_cfg.svh"

module tb_arith import arith_num_pkg::*, arith_ctl_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MW = `ARITH_MAG_W;
	localparam int UNIT_LAT = `ARITH_STEPS + 4;       // Start, load, steps, done, result register.
	localparam int NUM_TESTS = 33;                    // Commands issued over the whole run.
	localparam logic [31:0] LFSR_SEED = 32'h3e88_2fdc;

	logic clk;
	logic rst_n;
	logic cmd_valid;
	logic cmd_ready;
	cmd_t cmd;
	dword_t op_a;
	word_t op_b;
	logic res_valid;
	logic res_ready;
	word_t res_hi;
	word_t res_lo;
	status_t res_status;
	logic [31:0] lfsr_state;

	tb_clock_gen i_clk (.clk(clk), .rst_n(rst_n));

	arith_core i_dut (.*);

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_status(input status_t got, input status_t exp);
		if (got !== exp) begin
			$display("Error: res_status is 0x%h, expected 0x%h", got, exp);
			stop_run();
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp) begin
			$display("Error: res_valid latency is 0x%h cycles, expected 0x%h", got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
			stop_run();
		end
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'h8020_0003;                    // Taps 32, 22, 2, 1.
		end
		return n;
	endfunction

	function automatic logic [63:0] draw_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[62:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Sign-magnitude reference model.
	task automatic expect_result(input cmd_t c, input dword_t a, input word_t b,
			output word_t hi, output word_t lo, output status_t st);
		logic [63:0] x;
		logic [63:0] y;
		logic [63:0] q;
		logic [63:0] r;
		hi = '0;
		lo = '0;
		st = ST_OK;
		if (c == CMD_MUL) begin
			x = 64'(a[MW-1:0]) * 64'(b[MW-1:0]);
			hi = {(a[2*MW] ^ b[MW]) && (x != 64'd0), x[2*MW-1:MW]};
			lo = {1'b0, x[MW-1:0]};
		end else if (c == CMD_DIV) begin
			x = 64'(a[2*MW-1:0]);
			y = 64'(b[MW-1:0]);
			if (y == 64'd0 || (x >> MW) >= y) begin
				st = ST_OVERFLOW;
			end else begin
				q = x / y;
				r = x % y;
				hi = {(a[2*MW] ^ b[MW]) && (q != 64'd0), mag_t'(q)};
				lo = {a[2*MW] && (r != 64'd0), mag_t'(r)};
			end
		end else begin
			st = ST_ILLEGAL;
		end
	endtask

	// Called at a falling edge, returns at the first falling edge with res_valid high.
	task automatic run_cmd(input cmd_t c, input dword_t a, input word_t b, output int cycles);
		cmd_valid = 1'b1;
		cmd = c;
		op_a = a;
		op_b = b;
		@(negedge clk);
		cmd_valid = 1'b0;
		cycles = 1;
		while (!res_valid) begin
			if (cycles > 2 * UNIT_LAT) begin
				$display("No result arrived within %0d cycles of the command.", cycles);
				stop_run();
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic release_result();
		res_ready = 1'b1;
		@(negedge clk);
		res_ready = 1'b0;
		check_flag("res_valid", res_valid, 1'b0);
		check_flag("cmd_ready", cmd_ready, 1'b1);
	endtask

	// Result is checked again on every cycle that res_ready stays low.
	task automatic exec_command(input cmd_t c, input dword_t a, input word_t b, input int holds);
		word_t hi;
		word_t lo;
		status_t st;
		int cycles;
		expect_result(c, a, b, hi, lo, st);
		run_cmd(c, a, b, cycles);
		check_latency(cycles, (st == ST_ILLEGAL) ? 1 : UNIT_LAT);
		for (int h = 0; h <= holds; h++) begin
			check_flag("res_valid", res_valid, 1'b1);
			check_flag("cmd_ready", cmd_ready, 1'b0);
			check_word("res_hi", res_hi, hi);
			check_word("res_lo", res_lo, lo);
			check_status(res_status, st);
			if (h < holds) begin
				@(negedge clk);
			end
		end
		release_result();
	endtask

	task automatic after_reset();
		check_flag("cmd_ready", cmd_ready, 1'b1);
		check_flag("res_valid", res_valid, 1'b0);
	endtask

	task automatic divide_signs();
		mag_t d;
		mag_t hi_half;
		int shift;
		for (int n = 0; n < 8; n++) begin
			shift = int'(draw_bits(5));
			d = mag_t'(draw_bits(MW)) >> shift;
			if (d == '0) begin
				d = mag_t'(1);
			end
			hi_half = mag_t'(draw_bits(MW) % 64'(d));   // Keeps the quotient in 30 bits.
			exec_command(CMD_DIV, {n[1], hi_half, mag_t'(draw_bits(MW))}, {n[0], d}, 0);
		end
	endtask

	task automatic divide_overflow();
		mag_t d;
		d = mag_t'(draw_bits(MW)) | mag_t'(1);
		exec_command(CMD_DIV, {1'b0, dmag_t'(draw_bits(2 * MW))}, {1'b1, mag_t'(0)}, 0);
		exec_command(CMD_DIV, {1'b1, d, mag_t'(draw_bits(MW))}, {1'b0, d}, 0);
		exec_command(CMD_DIV, {1'b0, {MW{1'b1}}, mag_t'(draw_bits(MW))},
			{1'b1, (d >> 1) | mag_t'(1)}, 0);
	endtask

	task automatic multiply_signed();
		for (int n = 0; n < 6; n++) begin
			exec_command(CMD_MUL, dword_t'(draw_bits(2 * MW + 1)), word_t'(draw_bits(MW + 1)), 0);
		end
		exec_command(CMD_MUL, {1'b1, mag_t'(draw_bits(MW)), {MW{1'b1}}}, {1'b0, {MW{1'b1}}}, 0);
		exec_command(CMD_MUL, {1'b1, mag_t'(draw_bits(MW)), {MW{1'b1}}}, {1'b1, {MW{1'b1}}}, 0);
		exec_command(CMD_MUL, {1'b1, mag_t'(draw_bits(MW)), mag_t'(0)},
			{1'b0, mag_t'(draw_bits(MW))}, 0);
		exec_command(CMD_MUL, dword_t'(draw_bits(2 * MW + 1)), {1'b1, mag_t'(0)}, 0);
	endtask

	task automatic illegal_codes();
		for (int code = 0; code < 8; code++) begin
			if (code != int'(CMD_MUL) && code != int'(CMD_DIV)) begin
				exec_command(cmd_t'(code[2:0]), dword_t'(draw_bits(2 * MW + 1)),
					word_t'(draw_bits(MW + 1)), 0);
			end
		end
	endtask

	// Second command of each pair shows the core is free again.
	task automatic result_backpressure();
		for (int n = 0; n < 3; n++) begin
			exec_command(CMD_MUL, dword_t'(draw_bits(2 * MW + 1)), word_t'(draw_bits(MW + 1)),
				1 + int'(draw_bits(3)));
			exec_command(CMD_DIV, {1'b1, mag_t'(0), mag_t'(draw_bits(MW))}, {1'b0, {MW{1'b1}}}, 0);
		end
	endtask

	initial begin
		cmd_valid = 1'b0;
		cmd = CMD_MUL;
		op_a = '0;
		op_b = '0;
		res_ready = 1'b0;
		lfsr_state = LFSR_SEED;
		@(posedge rst_n);
		@(negedge clk);
		after_reset();
		divide_signs();
		divide_overflow();
		multiply_signed();
		illegal_codes();
		result_backpressure();
		$display("All tests passed!");
		$finish;
	end

	// About 30 cycles of 8 ns per command.
	initial begin
		#(NUM_TESTS * 30 * 8);
		$display("Watchdog timeout, the tests did not finish in time.");
		stop_run();
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
arith_num_pkg.sv
arith_ctl_pkg.sv
arith_unit_if.sv
mul_radix8.sv
div_radix8.sv
arith_core.sv
tb_clock_gen.sv
tb_arith.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs tb_arith with Verilator, the log decides pass or fail.
rm -f sim.log
verilator --binary --timing -j 0 -Wno-fatal --top-module tb_arith -f project.f -o tb_arith \
	&& ./obj_dir/tb_arith > sim.log 2>&1 \
	|| echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && echo "FAIL" && exit 1
echo "PASS"
exit 0
